//--- lfst_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "storeset_cfg.svh"

module lfst_tracker (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 i_clear,
    input  wire                                 i_stall,
    // rename lookup
    input  wire [`STORESET_RENAME_WIDTH-1:0]    i_lookup_vld,
    input  wire storeset_pkg::foldpc_t          i_foldpc [`STORESET_RENAME_WIDTH],
    output storeset_pkg::foldpc_t               o_rn_foldpc [`STORESET_RENAME_WIDTH],
    input  wire [`STORESET_RENAME_WIDTH-1:0]    i_rn_found,
    input  wire storeset_pkg::ssid_t            i_rn_ssid [`STORESET_RENAME_WIDTH],
    // dispatch
    input  wire [`STORESET_RENAME_WIDTH-1:0]    i_insert_store,
    input  wire storeset_pkg::rob_idx_t         i_alloc_rob_idx [`STORESET_RENAME_WIDTH],
    output logic [`STORESET_RENAME_WIDTH-1:0]   o_should_wait,
    output storeset_pkg::rob_idx_t              o_dep_rob_idx [`STORESET_RENAME_WIDTH],
    // store issue
    input  wire [`STORESET_ISSUE_WIDTH-1:0]     i_store_issued,
    input  wire storeset_pkg::foldpc_t          i_issue_foldpc [`STORESET_ISSUE_WIDTH],
    input  wire storeset_pkg::rob_idx_t         i_store_rob_idx [`STORESET_ISSUE_WIDTH],
    output storeset_pkg::foldpc_t               o_is_foldpc [`STORESET_ISSUE_WIDTH],
    input  wire [`STORESET_ISSUE_WIDTH-1:0]     i_is_found,
    input  wire storeset_pkg::ssid_t            i_is_ssid [`STORESET_ISSUE_WIDTH]
);
    import storeset_pkg::*;

    logic [`STORESET_LFST_SIZE-1:0]   lfst_vld;
    rob_idx_t                         lfst_rob [`STORESET_LFST_SIZE];

    logic [`STORESET_RENAME_WIDTH-1:0] s1_vld;
    ssid_t                             s1_ssid [`STORESET_RENAME_WIDTH];

    logic [`STORESET_ISSUE_WIDTH-1:0]  is_vld;
    ssid_t                             is_ssid [`STORESET_ISSUE_WIDTH];
    rob_idx_t                          is_rob [`STORESET_ISSUE_WIDTH];

    // ssit read addresses
    assign o_rn_foldpc = i_foldpc;
    assign o_is_foldpc = i_issue_foldpc;

    // stage 1, frozen while stalled
    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            s1_vld <= '0;
        end else if (!i_stall) begin
            s1_vld <= i_lookup_vld & i_rn_found;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            s1_ssid <= i_rn_ssid;
        end
    end

    // issue stage runs regardless of the stall
    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            is_vld <= '0;
        end else begin
            is_vld <= i_store_issued & i_is_found;
        end
    end

    always_ff @(posedge clk) begin
        is_ssid <= i_is_ssid;
        is_rob  <= i_store_rob_idx;
    end

    // release first, then insert, so an insert wins on the same entry
    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            lfst_vld <= '0;
        end else begin
            for (int p = 0; p < `STORESET_ISSUE_WIDTH; p++) begin
                if (is_vld[p] && lfst_vld[is_ssid[p]] && lfst_rob[is_ssid[p]] == is_rob[p]) begin
                    lfst_vld[is_ssid[p]] <= 1'b0;
                end
            end
            if (!i_stall) begin
                for (int s = 0; s < `STORESET_RENAME_WIDTH; s++) begin
                    if (s1_vld[s] && i_insert_store[s]) begin
                        lfst_vld[s1_ssid[s]] <= 1'b1;
                    end
                end
            end
        end
    end

    // younger slots come later in the loop and win on equal ssid
    always_ff @(posedge clk) begin
        if (!i_stall) begin
            for (int s = 0; s < `STORESET_RENAME_WIDTH; s++) begin
                if (s1_vld[s] && i_insert_store[s]) begin
                    lfst_rob[s1_ssid[s]] <= i_alloc_rob_idx[s];
                end
            end
        end
    end

    // producer lookup with bypass from older stores in the group
    always_comb begin
        for (int a = 0; a < `STORESET_RENAME_WIDTH; a++) begin
            o_should_wait[a] = 1'b0;
            o_dep_rob_idx[a] = '0;
            if (s1_vld[a] && lfst_vld[s1_ssid[a]]) begin
                o_should_wait[a] = 1'b1;
                o_dep_rob_idx[a] = lfst_rob[s1_ssid[a]];
            end
            // youngest older store overrides
            for (int b = 0; b < a; b++) begin
                if (s1_vld[a] && s1_vld[b] && i_insert_store[b] &&
                    s1_ssid[a] == s1_ssid[b]) begin
                    o_should_wait[a] = 1'b1;
                    o_dep_rob_idx[a] = i_alloc_rob_idx[b];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
storeset_pkg.sv
ssit_table.sv
storeset_trainer.sv
lfst_tracker.sv
storeset_predictor.sv
tb_clock_gen.sv
storeset_tb.sv

//--- ssit_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "storeset_cfg.svh"

module ssit_table (
    input  wire                     clk,
    input  wire                     rst,
    // rename lookups
    input  wire storeset_pkg::foldpc_t i_rn_foldpc [`STORESET_RENAME_WIDTH],
    output logic [`STORESET_RENAME_WIDTH-1:0] o_rn_found,
    output storeset_pkg::ssid_t     o_rn_ssid [`STORESET_RENAME_WIDTH],
    // store issue lookups
    input  wire storeset_pkg::foldpc_t i_is_foldpc [`STORESET_ISSUE_WIDTH],
    output logic [`STORESET_ISSUE_WIDTH-1:0] o_is_found,
    output storeset_pkg::ssid_t     o_is_ssid [`STORESET_ISSUE_WIDTH],
    // violation lookups
    input  wire storeset_pkg::foldpc_t i_vio_store_foldpc,
    input  wire storeset_pkg::foldpc_t i_vio_load_foldpc,
    output logic                    o_vio_store_found,
    output storeset_pkg::ssid_t     o_vio_store_ssid,
    output logic                    o_vio_load_found,
    output storeset_pkg::ssid_t     o_vio_load_ssid,
    // trainer writes
    input  wire [1:0]               i_wr_vld,
    input  wire storeset_pkg::foldpc_t i_wr_idx [2],
    input  wire storeset_pkg::ssid_t i_wr_ssid [2],
    // periodic clear
    output logic                    o_clear
);
    import storeset_pkg::*;

    localparam int CNT_W = $clog2(`STORESET_CLEAR_INTERVAL + 1);

    logic [`STORESET_SSIT_SIZE-1:0] ssit_vld;
    ssid_t                          ssit_mem [`STORESET_SSIT_SIZE];
    logic [CNT_W-1:0]               clr_cnt;

    assign o_clear = (clr_cnt == CNT_W'(`STORESET_CLEAR_INTERVAL));

    // free running interval counter, restarts on each clear
    always_ff @(posedge clk) begin
        if (rst || o_clear) begin
            clr_cnt <= '0;
        end else begin
            clr_cnt <= clr_cnt + 1'b1;
        end
    end

    // valid bits, port 1 is applied last so it wins on equal index
    always_ff @(posedge clk) begin
        if (rst || o_clear) begin
            ssit_vld <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (i_wr_vld[w]) begin
                    ssit_vld[i_wr_idx[w]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (i_wr_vld[w]) begin
                ssit_mem[i_wr_idx[w]] <= i_wr_ssid[w];
            end
        end
    end

    // asynchronous read ports
    always_comb begin
        for (int r = 0; r < `STORESET_RENAME_WIDTH; r++) begin
            o_rn_found[r] = ssit_vld[i_rn_foldpc[r]];
            o_rn_ssid[r]  = ssit_mem[i_rn_foldpc[r]];
        end
        for (int p = 0; p < `STORESET_ISSUE_WIDTH; p++) begin
            o_is_found[p] = ssit_vld[i_is_foldpc[p]];
            o_is_ssid[p]  = ssit_mem[i_is_foldpc[p]];
        end
    end

    assign o_vio_store_found = ssit_vld[i_vio_store_foldpc];
    assign o_vio_store_ssid  = ssit_mem[i_vio_store_foldpc];
    assign o_vio_load_found  = ssit_vld[i_vio_load_foldpc];
    assign o_vio_load_ssid   = ssit_mem[i_vio_load_foldpc];

endmodule

`default_nettype wire

//--- storeset_cfg.svh
`ifndef STORESET_CFG_SVH
`define STORESET_CFG_SVH

// lookups per rename group
`define STORESET_RENAME_WIDTH 4

// store issue ports
`define STORESET_ISSUE_WIDTH 2

// folded pc, indexes the ssit directly
`define STORESET_FOLDPC_WIDTH 10

// store set id, indexes the lfst directly
`define STORESET_SSID_WIDTH 5

// rob index carried by the lfst
`define STORESET_ROB_WIDTH 6

// table sizes follow from the index widths
`define STORESET_SSIT_SIZE (1 << `STORESET_FOLDPC_WIDTH)
`define STORESET_LFST_SIZE (1 << `STORESET_SSID_WIDTH)

// cycles between full table clears
`define STORESET_CLEAR_INTERVAL 25000

`endif

//--- storeset_pkg.sv
`default_nettype none

`include "storeset_cfg.svh"

package storeset_pkg;

    // folded instruction address
    typedef logic [`STORESET_FOLDPC_WIDTH-1:0] foldpc_t;

    // store set id
    typedef logic [`STORESET_SSID_WIDTH-1:0] ssid_t;

    // rob index of a store or load
    typedef logic [`STORESET_ROB_WIDTH-1:0] rob_idx_t;

endpackage

`default_nettype wire

//--- storeset_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "storeset_cfg.svh"

module storeset_predictor (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 i_stall,
    // rename lookup
    input  wire [`STORESET_RENAME_WIDTH-1:0]    i_lookup_vld,
    input  wire storeset_pkg::foldpc_t          i_foldpc [`STORESET_RENAME_WIDTH],
    // dispatch
    input  wire [`STORESET_RENAME_WIDTH-1:0]    i_insert_store,
    input  wire storeset_pkg::rob_idx_t         i_alloc_rob_idx [`STORESET_RENAME_WIDTH],
    output logic [`STORESET_RENAME_WIDTH-1:0]   o_should_wait,
    output storeset_pkg::rob_idx_t              o_dep_rob_idx [`STORESET_RENAME_WIDTH],
    // store issue
    input  wire [`STORESET_ISSUE_WIDTH-1:0]     i_store_issued,
    input  wire storeset_pkg::foldpc_t          i_issue_foldpc [`STORESET_ISSUE_WIDTH],
    input  wire storeset_pkg::rob_idx_t         i_store_rob_idx [`STORESET_ISSUE_WIDTH],
    // memory order violation
    input  wire                                 i_violation,
    input  wire storeset_pkg::foldpc_t          i_vio_store_foldpc,
    input  wire storeset_pkg::foldpc_t          i_vio_load_foldpc
);
    import storeset_pkg::*;

    foldpc_t                           rn_foldpc [`STORESET_RENAME_WIDTH];
    logic [`STORESET_RENAME_WIDTH-1:0] rn_found;
    ssid_t                             rn_ssid [`STORESET_RENAME_WIDTH];
    foldpc_t                           is_foldpc [`STORESET_ISSUE_WIDTH];
    logic [`STORESET_ISSUE_WIDTH-1:0]  is_found;
    ssid_t                             is_ssid [`STORESET_ISSUE_WIDTH];
    foldpc_t                           vio_store_foldpc;
    foldpc_t                           vio_load_foldpc;
    logic                              vio_store_found;
    ssid_t                             vio_store_ssid;
    logic                              vio_load_found;
    ssid_t                             vio_load_ssid;
    logic [1:0]                        wr_vld;
    foldpc_t                           wr_idx [2];
    ssid_t                             wr_ssid [2];
    logic                              clear;

    ssit_table u_ssit (
        .clk                (clk),
        .rst                (rst),
        .i_rn_foldpc        (rn_foldpc),
        .o_rn_found         (rn_found),
        .o_rn_ssid          (rn_ssid),
        .i_is_foldpc        (is_foldpc),
        .o_is_found         (is_found),
        .o_is_ssid          (is_ssid),
        .i_vio_store_foldpc (vio_store_foldpc),
        .i_vio_load_foldpc  (vio_load_foldpc),
        .o_vio_store_found  (vio_store_found),
        .o_vio_store_ssid   (vio_store_ssid),
        .o_vio_load_found   (vio_load_found),
        .o_vio_load_ssid    (vio_load_ssid),
        .i_wr_vld           (wr_vld),
        .i_wr_idx           (wr_idx),
        .i_wr_ssid          (wr_ssid),
        .o_clear            (clear)
    );

    storeset_trainer u_trainer (
        .clk                (clk),
        .rst                (rst),
        .i_clear            (clear),
        .i_violation        (i_violation),
        .i_vio_store_foldpc (i_vio_store_foldpc),
        .i_vio_load_foldpc  (i_vio_load_foldpc),
        .o_vio_store_foldpc (vio_store_foldpc),
        .o_vio_load_foldpc  (vio_load_foldpc),
        .i_store_found      (vio_store_found),
        .i_store_ssid       (vio_store_ssid),
        .i_load_found       (vio_load_found),
        .i_load_ssid        (vio_load_ssid),
        .o_wr_vld           (wr_vld),
        .o_wr_idx           (wr_idx),
        .o_wr_ssid          (wr_ssid)
    );

    lfst_tracker u_lfst (
        .clk             (clk),
        .rst             (rst),
        .i_clear         (clear),
        .i_stall         (i_stall),
        .i_lookup_vld    (i_lookup_vld),
        .i_foldpc        (i_foldpc),
        .o_rn_foldpc     (rn_foldpc),
        .i_rn_found      (rn_found),
        .i_rn_ssid       (rn_ssid),
        .i_insert_store  (i_insert_store),
        .i_alloc_rob_idx (i_alloc_rob_idx),
        .o_should_wait   (o_should_wait),
        .o_dep_rob_idx   (o_dep_rob_idx),
        .i_store_issued  (i_store_issued),
        .i_issue_foldpc  (i_issue_foldpc),
        .i_store_rob_idx (i_store_rob_idx),
        .o_is_foldpc     (is_foldpc),
        .i_is_found      (is_found),
        .i_is_ssid       (is_ssid)
    );

endmodule

`default_nettype wire

//--- storeset_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "storeset_cfg.svh"

module storeset_tb;
    import storeset_pkg::*;

    localparam int RW = `STORESET_RENAME_WIDTH;
    localparam int IW = `STORESET_ISSUE_WIDTH;
    localparam int RBW = `STORESET_ROB_WIDTH;
    localparam int CLEAR_TIMEOUT = `STORESET_CLEAR_INTERVAL + 5000;

    logic          clk;
    logic          rst;
    logic          stall;
    logic [RW-1:0] lookup_vld;
    foldpc_t       foldpc [RW];
    logic [RW-1:0] insert_store;
    rob_idx_t      alloc_rob [RW];
    logic [RW-1:0] should_wait;
    rob_idx_t      dep_rob [RW];
    logic [IW-1:0] store_issued;
    foldpc_t       issue_foldpc [IW];
    rob_idx_t      store_rob [IW];
    logic          violation;
    foldpc_t       vio_store;
    foldpc_t       vio_load;

    int errors = 0;
    int checks = 0;
    int wait_cycles = 0;
    int merge_hits [4];
    bit timed_out = 1'b0;
    bit clear_seen = 1'b0;

    // reference model state
    logic [`STORESET_SSIT_SIZE-1:0] m_ssit_vld;
    ssid_t                          m_ssit_mem [`STORESET_SSIT_SIZE];
    logic [`STORESET_LFST_SIZE-1:0] m_lfst_vld;
    rob_idx_t                       m_lfst_rob [`STORESET_LFST_SIZE];
    logic [RW-1:0]                  m_s1_vld;
    ssid_t                          m_s1_ssid [RW];
    logic [IW-1:0]                  m_is_vld;
    ssid_t                          m_is_ssid [IW];
    rob_idx_t                       m_is_rob [IW];
    logic                           m_t_vld;
    logic                           m_t_sf;
    logic                           m_t_lf;
    ssid_t                          m_t_ss;
    ssid_t                          m_t_ls;
    foldpc_t                        m_t_sidx;
    foldpc_t                        m_t_lidx;
    int                             m_cnt;

    logic [RW-1:0]     exp_wait;
    logic [RW*RBW-1:0] exp_dep;
    logic [RW*RBW-1:0] dut_dep;

    tb_clock_gen u_clk (.o_clk(clk));

    storeset_predictor uut (
        .clk                (clk),
        .rst                (rst),
        .i_stall            (stall),
        .i_lookup_vld       (lookup_vld),
        .i_foldpc           (foldpc),
        .i_insert_store     (insert_store),
        .i_alloc_rob_idx    (alloc_rob),
        .o_should_wait      (should_wait),
        .o_dep_rob_idx      (dep_rob),
        .i_store_issued     (store_issued),
        .i_issue_foldpc     (issue_foldpc),
        .i_store_rob_idx    (store_rob),
        .i_violation        (violation),
        .i_vio_store_foldpc (vio_store),
        .i_vio_load_foldpc  (vio_load)
    );

    // expected outputs from the model
    always_comb begin
        for (int a = 0; a < RW; a++) begin
            exp_wait[a] = 1'b0;
            exp_dep[a*RBW +: RBW] = '0;
            dut_dep[a*RBW +: RBW] = dep_rob[a];
            if (m_s1_vld[a]) begin
                if (m_lfst_vld[m_s1_ssid[a]]) begin
                    exp_wait[a] = 1'b1;
                    exp_dep[a*RBW +: RBW] = m_lfst_rob[m_s1_ssid[a]];
                end
                // youngest older store wins
                for (int b = 0; b < a; b++) begin
                    if (m_s1_vld[b] && insert_store[b] && m_s1_ssid[b] == m_s1_ssid[a]) begin
                        exp_wait[a] = 1'b1;
                        exp_dep[a*RBW +: RBW] = alloc_rob[b];
                    end
                end
            end
        end
    end

    property outputs_match;
        @(posedge clk) disable iff (rst)
            (should_wait == exp_wait) && (dut_dep == exp_dep);
    endproperty

    check_outputs: assert property (outputs_match) checks++;
    else begin
        errors++;
        $display("error %0t: wait=%b dep=%h, expected wait=%b dep=%h", $time,
                 $sampled(should_wait), $sampled(dut_dep),
                 $sampled(exp_wait), $sampled(exp_dep));
    end

    // ssit training for one violation by the four found cases
    task automatic apply_merge();
        merge_hits[{m_t_sf, m_t_lf}]++;
        if (!m_t_sf && !m_t_lf) begin
            m_ssit_vld[m_t_sidx] = 1'b1;
            m_ssit_mem[m_t_sidx] = m_t_ss;
            m_ssit_vld[m_t_lidx] = 1'b1;
            m_ssit_mem[m_t_lidx] = m_t_ss;
        end else if (!m_t_sf) begin
            m_ssit_vld[m_t_sidx] = 1'b1;
            m_ssit_mem[m_t_sidx] = m_t_ls;
        end else if (!m_t_lf) begin
            m_ssit_vld[m_t_lidx] = 1'b1;
            m_ssit_mem[m_t_lidx] = m_t_ss;
        end else if (m_t_ls > m_t_ss) begin
            m_ssit_mem[m_t_lidx] = m_t_ss;
        end else begin
            m_ssit_mem[m_t_sidx] = m_t_ls;
        end
    endtask

    task automatic model_step();
        logic          clr;
        logic [RW-1:0] rn_f;
        ssid_t         rn_s [RW];
        logic [IW-1:0] is_f;
        ssid_t         is_s [IW];
        logic          vs_f;
        logic          vl_f;
        ssid_t         vs_s;
        ssid_t         vl_s;
        clr = (m_cnt == `STORESET_CLEAR_INTERVAL);
        if (clr) begin
            clear_seen = 1'b1;
        end
        // reads see the table before this edge
        for (int r = 0; r < RW; r++) begin
            rn_f[r] = m_ssit_vld[foldpc[r]];
            rn_s[r] = m_ssit_mem[foldpc[r]];
        end
        for (int p = 0; p < IW; p++) begin
            is_f[p] = m_ssit_vld[issue_foldpc[p]];
            is_s[p] = m_ssit_mem[issue_foldpc[p]];
        end
        vs_f = m_ssit_vld[vio_store];
        vs_s = vs_f ? m_ssit_mem[vio_store] : vio_store[`STORESET_SSID_WIDTH-1:0];
        vl_f = m_ssit_vld[vio_load];
        vl_s = vl_f ? m_ssit_mem[vio_load] : vio_load[`STORESET_SSID_WIDTH-1:0];

        if (clr) begin
            m_ssit_vld = '0;
            m_lfst_vld = '0;
        end else begin
            if (m_t_vld) begin
                apply_merge();
            end
            for (int p = 0; p < IW; p++) begin
                if (m_is_vld[p] && m_lfst_rob[m_is_ssid[p]] == m_is_rob[p]) begin
                    m_lfst_vld[m_is_ssid[p]] = 1'b0;
                end
            end
            if (!stall) begin
                for (int s = 0; s < RW; s++) begin
                    if (m_s1_vld[s] && insert_store[s]) begin
                        m_lfst_vld[m_s1_ssid[s]] = 1'b1;
                        m_lfst_rob[m_s1_ssid[s]] = alloc_rob[s];
                    end
                end
            end
        end

        if (!stall) begin
            m_s1_vld = clr ? '0 : (lookup_vld & rn_f);
            m_s1_ssid = rn_s;
        end else if (clr) begin
            m_s1_vld = '0;
        end
        m_is_vld = clr ? '0 : (store_issued & is_f);
        m_is_ssid = is_s;
        m_is_rob = store_rob;
        m_t_vld = clr ? 1'b0 : violation;
        if (violation) begin
            m_t_sf = vs_f;
            m_t_lf = vl_f;
            m_t_ss = vs_s;
            m_t_ls = vl_s;
            m_t_sidx = vio_store;
            m_t_lidx = vio_load;
        end
        m_cnt = clr ? 0 : m_cnt + 1;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            m_ssit_vld = '0;
            m_lfst_vld = '0;
            m_s1_vld = '0;
            m_is_vld = '0;
            m_t_vld = 1'b0;
            m_cnt = 0;
        end else begin
            model_step();
            if (should_wait != '0) begin
                wait_cycles++;
            end
        end
    end

    // advance to 2 ns after the next edge and drop all strobes
    task automatic next_cycle();
        @(posedge clk);
        #2;
        stall = 1'b0;
        lookup_vld = '0;
        insert_store = '0;
        store_issued = '0;
        violation = 1'b0;
    endtask

    function automatic foldpc_t pool_addr();
        return foldpc_t'(10'h200 + $urandom_range(0, 23));
    endfunction

    task automatic random_cycle(input bit allow_vio, input bit prev_vio);
        for (int s = 0; s < RW; s++) begin
            foldpc[s] = pool_addr();
            alloc_rob[s] = rob_idx_t'($urandom_range(0, 7));
        end
        lookup_vld = RW'($urandom);
        insert_store = RW'($urandom);
        for (int p = 0; p < IW; p++) begin
            issue_foldpc[p] = pool_addr();
            store_rob[p] = rob_idx_t'($urandom_range(0, 7));
        end
        store_issued = IW'($urandom);
        stall = ($urandom_range(0, 4) == 0);
        // violations never back to back
        if (allow_vio && !prev_vio && $urandom_range(0, 2) == 0) begin
            vio_store = pool_addr();
            vio_load = pool_addr();
            if (vio_load == vio_store) begin
                vio_load = foldpc_t'(vio_store ^ 10'h001);
            end
            violation = 1'b1;
        end
    endtask

    task automatic run_random(input int n, input bit allow_vio);
        bit prev;
        prev = 1'b0;
        for (int i = 0; i < n; i++) begin
            random_cycle(allow_vio, prev);
            prev = violation;
            next_cycle();
        end
    endtask

    task automatic wait_for_clear();
        int count;
        bit prev;
        count = 0;
        // the last random cycle before this may have carried a violation
        prev = 1'b1;
        while (!clear_seen && !timed_out) begin
            random_cycle(1'b1, prev);
            prev = violation;
            next_cycle();
            count++;
            if (count > CLEAR_TIMEOUT) begin
                $display("timeout: the periodic table clear never happened");
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic lookup(input int slot, input foldpc_t pc);
        lookup_vld[slot] = 1'b1;
        foldpc[slot] = pc;
    endtask

    initial begin
        void'($urandom(90));
        for (int i = 0; i < `STORESET_SSIT_SIZE; i++) begin
            m_ssit_mem[i] = '0;
        end
        for (int i = 0; i < `STORESET_LFST_SIZE; i++) begin
            m_lfst_rob[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            merge_hits[i] = 0;
        end
        rst = 1'b1;
        stall = 1'b0;
        lookup_vld = '0;
        insert_store = '0;
        store_issued = '0;
        violation = 1'b0;
        vio_store = '0;
        vio_load = '0;
        for (int s = 0; s < RW; s++) begin
            foldpc[s] = '0;
            alloc_rob[s] = '0;
        end
        for (int p = 0; p < IW; p++) begin
            issue_foldpc[p] = '0;
            store_rob[p] = '0;
        end
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        // untrained traffic never waits
        run_random(50, 1'b0);

        // train store 0x010 with load 0x020
        violation = 1'b1;
        vio_store = 10'h010;
        vio_load = 10'h020;
        next_cycle();
        next_cycle();
        lookup(0, 10'h010);
        next_cycle();
        insert_store[0] = 1'b1;
        alloc_rob[0] = 6'd5;
        lookup(1, 10'h020);
        next_cycle();
        next_cycle();

        // store and younger load in one group with an older lfst entry present
        lookup(0, 10'h010);
        lookup(2, 10'h020);
        next_cycle();
        insert_store[0] = 1'b1;
        alloc_rob[0] = 6'd9;
        alloc_rob[2] = 6'd11;
        next_cycle();

        // issue with a stale rob index keeps the entry
        store_issued[0] = 1'b1;
        issue_foldpc[0] = 10'h010;
        store_rob[0] = 6'd5;
        next_cycle();
        next_cycle();
        lookup(1, 10'h020);
        next_cycle();
        next_cycle();

        // matching issue releases it
        store_issued[1] = 1'b1;
        issue_foldpc[1] = 10'h010;
        store_rob[1] = 6'd9;
        next_cycle();
        next_cycle();
        lookup(1, 10'h020);
        next_cycle();
        next_cycle();

        if (wait_cycles == 0) begin
            $display("directed groups never produced a waiting load");
            errors++;
        end

        run_random(3000, 1'b1);
        for (int i = 0; i < 4; i++) begin
            if (merge_hits[i] == 0) begin
                $display("violation case %0d was never trained", i);
                errors++;
            end
        end

        wait_for_clear();
        if (!timed_out) begin
            // trained pair from before the clear
            lookup(0, 10'h010);
            next_cycle();
            insert_store[0] = 1'b1;
            alloc_rob[0] = 6'd3;
            lookup(1, 10'h020);
            next_cycle();
            next_cycle();
            next_cycle();
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (timed_out || errors != 0) begin
            $display("Test failed");
        end else begin
            $display("Test passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- storeset_trainer.sv
`timescale 1ns/1ps
`default_nettype none

`include "storeset_cfg.svh"

module storeset_trainer (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        i_clear,
    // violation report
    input  wire                        i_violation,
    input  wire storeset_pkg::foldpc_t i_vio_store_foldpc,
    input  wire storeset_pkg::foldpc_t i_vio_load_foldpc,
    // ssit read results for the two addresses
    output storeset_pkg::foldpc_t      o_vio_store_foldpc,
    output storeset_pkg::foldpc_t      o_vio_load_foldpc,
    input  wire                        i_store_found,
    input  wire storeset_pkg::ssid_t   i_store_ssid,
    input  wire                        i_load_found,
    input  wire storeset_pkg::ssid_t   i_load_ssid,
    // ssit write ports, 0 for the store entry, 1 for the load entry
    output logic [1:0]                 o_wr_vld,
    output storeset_pkg::foldpc_t      o_wr_idx [2],
    output storeset_pkg::ssid_t        o_wr_ssid [2]
);
    import storeset_pkg::*;

    logic    s1_vld;
    logic    s1_store_found;
    logic    s1_load_found;
    ssid_t   s1_store_ssid;
    ssid_t   s1_load_ssid;
    foldpc_t s1_store_idx;
    foldpc_t s1_load_idx;

    // stage 1 reads the ssit through these
    assign o_vio_store_foldpc = i_vio_store_foldpc;
    assign o_vio_load_foldpc  = i_vio_load_foldpc;

    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            s1_vld <= 1'b0;
        end else begin
            s1_vld <= i_violation;
        end
    end

    // found flags are refreshed on every violation
    always_ff @(posedge clk) begin
        if (i_violation) begin
            s1_store_found <= i_store_found;
            s1_load_found  <= i_load_found;
            // unknown address gets a fresh id from its low bits
            s1_store_ssid  <= i_store_found ? i_store_ssid
                                            : i_vio_store_foldpc[`STORESET_SSID_WIDTH-1:0];
            s1_load_ssid   <= i_load_found ? i_load_ssid
                                           : i_vio_load_foldpc[`STORESET_SSID_WIDTH-1:0];
            s1_store_idx   <= i_vio_store_foldpc;
            s1_load_idx    <= i_vio_load_foldpc;
        end
    end

    assign o_wr_idx[0] = s1_store_idx;
    assign o_wr_idx[1] = s1_load_idx;

    // stage 2 merge decision
    always_comb begin
        o_wr_vld     = 2'b00;
        o_wr_ssid[0] = s1_store_ssid;
        o_wr_ssid[1] = s1_store_ssid;
        if (s1_vld) begin
            case ({s1_store_found, s1_load_found})
                // new set named after the store, both join it
                2'b00: o_wr_vld = 2'b11;
                // store joins the load's set
                2'b01: begin
                    o_wr_vld     = 2'b01;
                    o_wr_ssid[0] = s1_load_ssid;
                end
                // load joins the store's set
                2'b10: o_wr_vld = 2'b10;
                // both known, the larger id gives way
                default: begin
                    if (s1_store_ssid > s1_load_ssid) begin
                        o_wr_vld     = 2'b01;
                        o_wr_ssid[0] = s1_load_ssid;
                    end else begin
                        o_wr_vld     = 2'b10;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic o_clk
);
    // 20 ns period
    localparam real HALF_PERIOD = 10.0;

    initial begin
        o_clk = 1'b0;
        forever begin
            #(HALF_PERIOD) o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire
